/* mipsCpu.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/cpuControl.sv
rtl/registerFile.sv
rtl/executeUnit.sv
rtl/mipsCpuBus.sv
verif/avalonMemory.sv
verif/mipsCpuTb.sv

/* rtl/cpuControl.sv */
`include "mipsCpu_cfg.svh"

module cpuControl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 waitrequest,
    input  mipsPkg::word_t       readdata,
    output mipsPkg::word_t       address,
    output mipsPkg::word_t       writedata,
    output logic                 read,
    output logic                 write,
    output logic                 active,
    output mipsPkg::byteEnable_t byteenable,
    output mipsPkg::word_t       pc,
    output mipsPkg::word_t       instruction,
    // From execute unit
    input  logic                 isLoad,
    input  logic                 isStore,
    input  logic                 writeEnable,
    input  mipsPkg::regAddr_t    writeReg,
    input  mipsPkg::word_t       result,
    input  mipsPkg::word_t       memAddress,
    input  mipsPkg::word_t       storeData,
    input  mipsPkg::word_t       nextPc,
    // Register file write port
    output logic                 regWrite,
    output mipsPkg::regAddr_t    regWriteAddr,
    output mipsPkg::word_t       regWriteData
);
    import mipsPkg::*;

    cpuState_t state, stateNext;
    logic      memOp;        // Current instruction touches data memory
    logic      accepted;     // Bus transfer completes this cycle
    logic      haltNext;     // Next PC hits the stop address

    assign memOp    = isLoad || isStore;
    assign accepted = (read || write) && !waitrequest;
    assign haltNext = (nextPc == `HALT_ADDRESS);

    // Core only runs until it jumps to the halt address
    assign active = (state != HALT);

    // Instruction fetch at PC, data access at computed address
    assign address    = (state == MEMORY) ? memAddress : pc;
    assign writedata  = storeData;
    assign byteenable = 4'b1111;     // Word accesses only

    // Next-state logic
    always_comb begin
        stateNext = state;
        case (state)
            FETCH: begin
                if (accepted) begin
                    stateNext = EXECUTE;
                end
            end
            EXECUTE: begin
                if (memOp) begin
                    stateNext = MEMORY;
                end else if (haltNext) begin
                    stateNext = HALT;
                end else begin
                    stateNext = FETCH;
                end
            end
            MEMORY: begin
                if (accepted) begin
                    stateNext = FETCH;     // Back to fetch at PC+4
                end
            end
            default: begin
                stateNext = HALT;          // Stays here until reset
            end
        endcase
    end

    // Register writeback
    // ALU ops write in EXECUTE, loads when the read data arrives
    always_comb begin
        regWrite     = 1'b0;
        regWriteAddr = writeReg;
        regWriteData = result;
        if (state == EXECUTE) begin
            regWrite = writeEnable && !memOp;
        end else if (state == MEMORY) begin
            regWrite     = isLoad && accepted;
            regWriteData = readdata;       // Full word load
        end
    end

    // Bus commands are registered from the next state
    // so they change only on a clock edge
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `RESET_VECTOR;
            read  <= 1'b0;
            write <= 1'b0;
        end else begin
            state <= stateNext;
            read  <= (stateNext == FETCH) || ((stateNext == MEMORY) && isLoad);
            write <= (stateNext == MEMORY) && isStore;
            if (state == EXECUTE && !memOp) begin
                pc <= nextPc;              // Branch, jump or fall-through
            end else if (state == MEMORY && accepted) begin
                pc <= nextPc;              // PC+4 for loads and stores
            end
        end
    end

    // Instruction register, captured at the end of fetch
    always_ff @(posedge clk) begin
        if (state == FETCH && accepted) begin
            instruction <= readdata;
        end
    end

endmodule

/* rtl/executeUnit.sv */
module executeUnit (
    input  mipsPkg::word_t    pc,
    input  mipsPkg::word_t    instruction,
    input  mipsPkg::word_t    rsValue,
    input  mipsPkg::word_t    rtValue,
    output mipsPkg::regAddr_t rsAddr,
    output mipsPkg::regAddr_t rtAddr,
    output mipsPkg::word_t    result,
    output mipsPkg::word_t    memAddress,
    output mipsPkg::word_t    storeData,
    output mipsPkg::word_t    nextPc,
    output logic              writeEnable,
    output logic              isLoad,
    output logic              isStore,
    output mipsPkg::regAddr_t writeReg
);
    import mipsPkg::*;

    opcode_t     opcode;
    funct_t      funct;
    regAddr_t    rdAddr;
    shamt_t      shamt;
    imm_t        imm;
    logic [25:0] target;           // J-type index
    word_t       immSext, immZext;
    word_t       pcPlus4, branchTarget, jumpTarget;
    aluOp_t      aluOp;
    word_t       operandB;         // rt or extended immediate

    // Field split
    assign opcode = opcode_t'(instruction[31:26]);
    assign rsAddr = instruction[25:21];
    assign rtAddr = instruction[20:16];
    assign rdAddr = instruction[15:11];
    assign shamt  = instruction[10:6];
    assign funct  = funct_t'(instruction[5:0]);
    assign imm    = instruction[15:0];
    assign target = instruction[25:0];

    assign immSext = {{16{imm[15]}}, imm};
    assign immZext = {16'h0000, imm};

    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};  // No delay slot
    assign jumpTarget   = {pcPlus4[31:28], target, 2'b00};

    assign memAddress = rsValue + immSext;  // Base plus offset
    assign storeData  = rtValue;

    // Decode
    always_comb begin
        aluOp       = ALU_PASS;
        operandB    = rtValue;
        writeEnable = 1'b0;
        writeReg    = rdAddr;
        isLoad      = 1'b0;
        isStore     = 1'b0;
        nextPc      = pcPlus4;
        case (opcode)
            OP_SPECIAL: begin
                writeEnable = 1'b1;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLTU: aluOp = ALU_SLTU;
                    FN_SLL:  aluOp = ALU_SLL;
                    FN_SRL:  aluOp = ALU_SRL;
                    FN_SRA:  aluOp = ALU_SRA;
                    FN_JR: begin
                        writeEnable = 1'b0;
                        nextPc      = rsValue;
                    end
                    default: writeEnable = 1'b0;   // Unknown funct is a no-op
                endcase
            end
            OP_J:   nextPc = jumpTarget;
            OP_BEQ: nextPc = (rsValue == rtValue) ? branchTarget : pcPlus4;
            OP_BNE: nextPc = (rsValue != rtValue) ? branchTarget : pcPlus4;
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                writeEnable = 1'b1;
                writeReg    = rtAddr;               // Immediates target rt
                operandB    = immSext;
                case (opcode)
                    OP_ADDIU: aluOp = ALU_ADD;
                    OP_SLTI:  aluOp = ALU_SLT;
                    OP_ANDI: begin
                        aluOp    = ALU_AND;
                        operandB = immZext;         // Logical ops zero-extend
                    end
                    OP_ORI: begin
                        aluOp    = ALU_OR;
                        operandB = immZext;
                    end
                    OP_XORI: begin
                        aluOp    = ALU_XOR;
                        operandB = immZext;
                    end
                    default: aluOp = ALU_LUI;
                endcase
            end
            OP_LW: begin
                isLoad      = 1'b1;
                writeEnable = 1'b1;   // Control commits it when data arrives
                writeReg    = rtAddr;
            end
            OP_SW:   isStore = 1'b1;
            default: writeEnable = 1'b0;           // Unknown opcode, fall through
        endcase
    end

    // ALU, operand A is always rs
    always_comb begin
        case (aluOp)
            ALU_ADD:  result = rsValue + operandB;
            ALU_SUB:  result = rsValue - operandB;
            ALU_AND:  result = rsValue & operandB;
            ALU_OR:   result = rsValue | operandB;
            ALU_XOR:  result = rsValue ^ operandB;
            ALU_SLT:  result = {31'b0, $signed(rsValue) < $signed(operandB)};
            ALU_SLTU: result = {31'b0, rsValue < operandB};
            ALU_SLL:  result = operandB << shamt;           // Shifts act on rt
            ALU_SRL:  result = operandB >> shamt;
            ALU_SRA:  result = word_t'($signed(operandB) >>> shamt);
            ALU_LUI:  result = {operandB[15:0], 16'h0000};  // Immediate to upper half
            default:  result = operandB;
        endcase
    end

endmodule

/* rtl/mipsCpuBus.sv */
module mipsCpuBus (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 active,
    output mipsPkg::word_t       registerV0,
    // Avalon-MM master
    output mipsPkg::word_t       address,
    output logic                 write,
    output logic                 read,
    input  logic                 waitrequest,
    output mipsPkg::word_t       writedata,
    output mipsPkg::byteEnable_t byteenable,
    input  mipsPkg::word_t       readdata
);
    import mipsPkg::*;

    word_t    pc, instruction;          // From control
    regAddr_t rsAddr, rtAddr;           // Decoded source registers
    word_t    rsValue, rtValue;
    word_t    result, memAddress, storeData, nextPc;
    logic     writeEnable, isLoad, isStore;
    regAddr_t writeReg;
    logic     regWrite;                 // Qualified write port
    regAddr_t regWriteAddr;
    word_t    regWriteData;

    cpuControl control (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .address(address), .writedata(writedata), .read(read), .write(write),
        .active(active), .byteenable(byteenable), .pc(pc), .instruction(instruction),
        .isLoad(isLoad), .isStore(isStore), .writeEnable(writeEnable), .writeReg(writeReg),
        .result(result), .memAddress(memAddress), .storeData(storeData), .nextPc(nextPc),
        .regWrite(regWrite), .regWriteAddr(regWriteAddr), .regWriteData(regWriteData)
    );

    registerFile regs (
        .clk(clk), .reset(reset),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsValue(rsValue), .rtValue(rtValue),
        .writeEn(regWrite), .writeAddr(regWriteAddr), .writeData(regWriteData),
        .v0Value(registerV0)
    );

    executeUnit execute (
        .pc(pc), .instruction(instruction), .rsValue(rsValue), .rtValue(rtValue),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .result(result), .memAddress(memAddress),
        .storeData(storeData), .nextPc(nextPc), .writeEnable(writeEnable),
        .isLoad(isLoad), .isStore(isStore), .writeReg(writeReg)
    );

endmodule

/* rtl/mipsCpu_cfg.svh */
`ifndef MIPS_CPU_CFG_SVH
`define MIPS_CPU_CFG_SVH

// Boot ROM location, first fetch after reset
`define RESET_VECTOR 32'hBFC0_0000

// Jumping here stops the core
`define HALT_ADDRESS 32'h0000_0000

// General register file size
`define NUM_REGS 32

// Result register brought out for observation ($v0)
`define REG_V0 5'd2

`endif

/* rtl/mipsPkg.sv */
package mipsPkg;

    typedef logic [31:0] word_t;       // Data, address, instruction
    typedef logic [4:0]  regAddr_t;    // Register number
    typedef logic [4:0]  shamt_t;      // Shift amount field
    typedef logic [15:0] imm_t;        // Immediate field
    typedef logic [3:0]  byteEnable_t; // Avalon byte lanes

    // Primary opcodes, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'd0,  // R-type, decoded by funct
        OP_J       = 6'd2,
        OP_BEQ     = 6'd4,
        OP_BNE     = 6'd5,
        OP_ADDIU   = 6'd9,
        OP_SLTI    = 6'd10,
        OP_ANDI    = 6'd12,
        OP_ORI     = 6'd13,
        OP_XORI    = 6'd14,
        OP_LUI     = 6'd15,
        OP_LW      = 6'd35,
        OP_SW      = 6'd43
    } opcode_t;

    // R-type function codes, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS
    } aluOp_t;

    typedef enum logic [1:0] {
        FETCH   = 2'd0,
        EXECUTE = 2'd1,
        MEMORY  = 2'd2,
        HALT    = 2'd3
    } cpuState_t;

endpackage

/* rtl/registerFile.sv */
`include "mipsCpu_cfg.svh"

module registerFile (
    input  logic              clk,
    input  logic              reset,
    input  mipsPkg::regAddr_t rsAddr,
    input  mipsPkg::regAddr_t rtAddr,
    output mipsPkg::word_t    rsValue,
    output mipsPkg::word_t    rtValue,
    input  logic              writeEn,
    input  mipsPkg::regAddr_t writeAddr,
    input  mipsPkg::word_t    writeData,
    output mipsPkg::word_t    v0Value
);
    import mipsPkg::*;

    word_t regs [`NUM_REGS];

    // Combinational reads, $zero forced
    assign rsValue = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtValue = (rtAddr == '0) ? '0 : regs[rtAddr];
    assign v0Value = regs[`REG_V0];    // Observation port

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;  // Writes to $zero dropped
        end
    end

endmodule

/* verif/avalonMemory.sv */
module avalonMemory #(
    parameter int          MEM_WORDS = 1024,
    parameter logic [31:0] SEED      = 32'h8b04
) (
    input  logic                 clk,
    input  mipsPkg::word_t       address,
    input  logic                 read,
    input  logic                 write,
    input  mipsPkg::word_t       writedata,
    input  mipsPkg::byteEnable_t byteenable,
    output mipsPkg::word_t       readdata,
    output logic                 waitrequest
);
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int INDEX_BITS = $clog2(MEM_WORDS);

    word_t                 words [MEM_WORDS];    // Loaded directly by the testbench
    logic [INDEX_BITS-1:0] index;
    logic [31:0]           randState = SEED;
    logic [1:0]            waitLeft = 2'd0;      // Wait states still owed
    logic                  busy = 1'b0;          // Command seen, not yet accepted
    // Record of the last accepted write
    word_t                 lastWriteAddress = '0;
    byteEnable_t           lastWriteEnables = '0;
    int                    writeCount = 0;

    assign index = address[INDEX_BITS+1:2];      // Upper bits alias, reset vector lands on word 0

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        readdata    = '0;
        waitrequest = 1'b0;
    end

    // Command is stable 1 ns after the edge, answer for this cycle
    always @(posedge clk) begin
        #1;
        if (read || write) begin
            if (!busy) begin
                randState = lcgStep(randState);
                waitLeft  = randState[31:30];    // 0 to 3 wait states per transfer
                busy      = 1'b1;
            end
            waitrequest = (waitLeft != 2'd0);
            if (waitrequest) begin
                waitLeft = waitLeft - 2'd1;
            end else begin
                busy = 1'b0;                     // Accepted at the coming edge
                if (read) begin
                    readdata = words[index];
                end else begin
                    for (int lane = 0; lane < 4; lane++) begin
                        if (byteenable[lane]) begin
                            words[index][lane*8 +: 8] = writedata[lane*8 +: 8];
                        end
                    end
                    lastWriteAddress = address;
                    lastWriteEnables = byteenable;
                    writeCount       = writeCount + 1;
                end
            end
        end else begin
            waitrequest = 1'b0;                  // Idle bus
            busy        = 1'b0;
        end
    end

endmodule

/* verif/mipsCpuTb.sv */
`include "mipsCpu_cfg.svh"

module mipsCpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import mipsPkg::*;

    localparam int          NUM_ROWS    = 27;
    localparam int          MEM_WORDS   = 1024;
    localparam int          PROG_BASE   = (`RESET_VECTOR >> 2) % MEM_WORDS;  // Word 0 here
    localparam logic [15:0] DATA_BASE   = 16'h0800;     // Word 512 up and clear of the program
    localparam logic [31:0] SEED        = 32'h8b04;
    localparam int          TIMEOUT_NS  = NUM_ROWS * 40 * 5 * 4;
    localparam int          KIND_R      = 0;
    localparam int          KIND_IMM    = 1;
    localparam int          KIND_MEM    = 2;
    localparam int          KIND_BRANCH = 3;
    localparam regAddr_t    REG_T0      = 5'd8;
    localparam regAddr_t    REG_T1      = 5'd9;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        active, read, write, waitrequest;
    word_t       registerV0, address, writedata, readdata;
    byteEnable_t byteenable;
    logic [31:0] randState = SEED;
    // Test table of kind, operation, operands and expected $v0
    int          rowKind [$];
    logic [5:0]  rowOp [$];
    word_t       rowA [$];
    word_t       rowB [$];
    word_t       rowExpected [$];

    always #2 clk = ~clk;    // 4 ns period

    mipsCpuBus UUT (
        .clk(clk), .reset(reset), .active(active), .registerV0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    avalonMemory #(.MEM_WORDS(MEM_WORDS), .SEED(SEED)) memModel (
        .clk(clk), .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .readdata(readdata), .waitrequest(waitrequest)
    );

    function automatic logic [31:0] lcgStep(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Upper halves only since low LCG bits repeat quickly
    function automatic word_t randomWord();
        logic [31:0] first;
        first     = lcgStep(randState);
        randState = lcgStep(first);
        return {first[31:16], randState[31:16]};
    endfunction

    function automatic word_t rType(input regAddr_t rs, input regAddr_t rt, input regAddr_t rd,
                                    input shamt_t sh, input logic [5:0] fn);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regAddr_t rs, input regAddr_t rt,
                                    input imm_t imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] dataOffset(input word_t b);
        return DATA_BASE | {6'd0, b[9:2], 2'b00};   // Word aligned within 256 words
    endfunction

    // Signed less-than from the sign bits or an unsigned compare when they agree
    function automatic word_t signedLess(input word_t a, input word_t b);
        return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    endfunction

    // ISA rule for the value $v0 must hold at halt
    function automatic word_t ruleResult(input int kind, input logic [5:0] op,
                                         input word_t a, input word_t b);
        word_t      sext;
        word_t      zext;
        logic [4:0] sh;
        sext = {{16{b[15]}}, b[15:0]};
        zext = {16'h0000, b[15:0]};
        sh   = a[4:0];                              // Shift amount taken from operand A
        if (kind == KIND_MEM) begin
            return a;                               // Load gives back the stored word
        end else if (kind == KIND_BRANCH) begin
            if (op == OP_J) begin
                return 32'd2;
            end else if (op == OP_BEQ) begin
                return (a == b) ? 32'd2 : 32'd1;
            end
            return (a != b) ? 32'd2 : 32'd1;
        end else if (kind == KIND_IMM) begin
            case (op)
                OP_ADDIU: return a + sext;
                OP_SLTI:  return signedLess(a, sext);
                OP_ANDI:  return a & zext;
                OP_ORI:   return a | zext;
                OP_XORI:  return a ^ zext;
                default:  return {b[15:0], 16'h0000};   // LUI
            endcase
        end
        case (op)
            FN_ADDU: return a + b;
            FN_SUBU: return a - b;
            FN_AND:  return a & b;
            FN_OR:   return a | b;
            FN_XOR:  return a ^ b;
            FN_SLT:  return signedLess(a, b);
            FN_SLTU: return {31'd0, a < b};
            FN_SLL:  return b << sh;
            FN_SRL:  return b >> sh;
            default: return (b >> sh) | (b[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0);  // SRA
        endcase
    endfunction

    task automatic addRow(input int kind, input logic [5:0] op, input word_t a, input word_t b);
        rowKind.push_back(kind);
        rowOp.push_back(op);
        rowA.push_back(a);
        rowB.push_back(b);
        rowExpected.push_back(ruleResult(kind, op, a, b));
    endtask

    task automatic addRandomRow(input int kind, input logic [5:0] op);
        word_t a;
        word_t b;
        a = randomWord();
        b = randomWord();
        addRow(kind, op, a, b);
    endtask

    task automatic buildTable();
        word_t a;
        word_t b;
        addRandomRow(KIND_R, FN_ADDU);
        addRandomRow(KIND_R, FN_SUBU);
        addRandomRow(KIND_R, FN_AND);
        addRandomRow(KIND_R, FN_OR);
        addRandomRow(KIND_R, FN_XOR);
        addRandomRow(KIND_R, FN_SLT);
        addRandomRow(KIND_R, FN_SLTU);
        addRandomRow(KIND_R, FN_SLL);
        addRandomRow(KIND_R, FN_SRL);
        addRandomRow(KIND_R, FN_SRA);
        addRandomRow(KIND_IMM, OP_ADDIU);
        addRandomRow(KIND_IMM, OP_SLTI);
        addRandomRow(KIND_IMM, OP_ANDI);
        addRandomRow(KIND_IMM, OP_ORI);
        addRandomRow(KIND_IMM, OP_XORI);
        addRandomRow(KIND_IMM, OP_LUI);
        addRandomRow(KIND_MEM, 6'd0);
        addRandomRow(KIND_MEM, 6'd0);
        a = randomWord();
        b = randomWord();
        addRow(KIND_R, FN_SLT, a | 32'h8000_0000, b & 32'h7FFF_FFFF);   // Mixed signs
        addRow(KIND_R, FN_SLTU, a | 32'h8000_0000, b & 32'h7FFF_FFFF);
        addRow(KIND_IMM, OP_ADDIU, a, b | 32'h0000_8000);   // Negative immediate
        addRow(KIND_IMM, OP_ORI, a, b | 32'h0000_8000);     // Bit 15 must not spread
        addRow(KIND_BRANCH, OP_BEQ, a, a);                  // Taken
        addRow(KIND_BRANCH, OP_BEQ, a, ~a);
        addRow(KIND_BRANCH, OP_BNE, a, a);
        addRow(KIND_BRANCH, OP_BNE, a, ~a);                 // Taken
        addRow(KIND_BRANCH, OP_J, a, b);
    endtask

    task automatic putWord(input int slot, input word_t value);
        memModel.words[PROG_BASE + slot] = value;
    endtask

    // Loads $t0 and $t1 then runs the operation under test into $v0
    task automatic loadProgram(input int kind, input logic [5:0] op, input word_t a,
                               input word_t b);
        word_t jrZero;
        word_t jumpAddr;
        jrZero   = rType(5'd0, 5'd0, 5'd0, 5'd0, FN_JR);     // Jump to the halt address
        jumpAddr = (`RESET_VECTOR + 32'd28) >> 2;            // Word 7
        for (int i = 0; i < MEM_WORDS; i++) begin
            memModel.words[i] = 32'hFC00_0000 | i;           // Unused opcode tagged with index
        end
        putWord(0, iType(OP_LUI, 5'd0, REG_T0, a[31:16]));
        putWord(1, iType(OP_ORI, REG_T0, REG_T0, a[15:0]));
        putWord(2, iType(OP_LUI, 5'd0, REG_T1, b[31:16]));
        putWord(3, iType(OP_ORI, REG_T1, REG_T1, b[15:0]));
        case (kind)
            KIND_R: begin
                if (op == FN_SLL || op == FN_SRL || op == FN_SRA) begin
                    putWord(4, rType(5'd0, REG_T1, `REG_V0, a[4:0], op));
                end else begin
                    putWord(4, rType(REG_T0, REG_T1, `REG_V0, 5'd0, op));
                end
                putWord(5, jrZero);
            end
            KIND_IMM: begin
                putWord(4, iType(op, (op == OP_LUI) ? 5'd0 : REG_T0, `REG_V0, b[15:0]));
                putWord(5, jrZero);
            end
            KIND_MEM: begin
                putWord(4, iType(OP_SW, 5'd0, REG_T0, dataOffset(b)));
                putWord(5, iType(OP_LW, 5'd0, `REG_V0, dataOffset(b)));
                putWord(6, jrZero);
            end
            default: begin
                if (op == OP_J) begin
                    putWord(4, {OP_J, jumpAddr[25:0]});
                end else begin
                    putWord(4, iType(op, REG_T0, REG_T1, 16'd2));   // Skips two words
                end
                putWord(5, iType(OP_ORI, 5'd0, `REG_V0, 16'd1));    // Fall-through marker
                putWord(6, jrZero);
                putWord(7, iType(OP_ORI, 5'd0, `REG_V0, 16'd2));    // Target marker
                putWord(8, jrZero);
            end
        endcase
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic runRow(input int row);
        word_t       haltV0;
        logic [15:0] offset;
        reset = 1'b1;
        loadProgram(rowKind[row], rowOp[row], rowA[row], rowB[row]);
        memModel.writeCount = 0;
        waitCycles(3);
        checkValue("read", read, 0);                     // Bus quiet in reset
        checkValue("write", write, 0);
        reset = 1'b0;
        checkValue("active", active, 1);
        while (read !== 1'b1) begin
            waitCycles(1);
        end
        checkValue("address", address, `RESET_VECTOR);  // First fetch
        while (active === 1'b1) begin
            waitCycles(1);
        end
        checkValue("registerV0", registerV0, rowExpected[row]);
        haltV0 = registerV0;
        repeat (20) begin
            waitCycles(1);
            checkValue("active", active, 0);
            checkValue("read", read, 0);
            checkValue("write", write, 0);
            checkValue("registerV0", registerV0, haltV0);  // Frozen while halted
        end
        if (rowKind[row] == KIND_MEM) begin
            offset = dataOffset(rowB[row]);
            checkValue("memory word", memModel.words[offset[11:2]], rowA[row]);
            checkValue("write count", memModel.writeCount, 1);
            checkValue("write address", memModel.lastWriteAddress, {16'h0000, offset});
            checkValue("byteenable", memModel.lastWriteEnables, 32'hF);
        end
    endtask

    initial begin
        buildTable();
        for (int row = 0; row < rowKind.size(); row++) begin
            runRow(row);
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test table did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule
